//--- boot.hex
// Boot ROM words 0 to 15, one 32-bit hex word per line
00000297
02028293
30529073
10000537
00050513
0005a583
00b52023
00450513
fff58593
fe059ae3
0000006f
deadbeef
13579bdf
2468ace0
a5a5c3c3
0f1e2d3c

//--- tb.f
soc_pkg.sv
arb_pkg.sv
boot_mem.sv
dcache_port_arbiter.sv
mem_arbiter.sv
main_mem.sv
mem_top.sv
tb_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_mem_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mem_top.sv
`default_nettype none

module tb_mem_top;
    import soc_pkg::*;
    import arb_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int N_TXN       = 100;   // Per request stream
    localparam int FILL_BASE   = 224;   // Shared read region, written before the streams
    localparam int FILL_WORDS  = 32;
    localparam int N_RACE      = 8;     // Same-cycle rounds, five accesses each
    localparam int CYCLE_LIMIT = (3*N_TXN + FILL_WORDS + 5*N_RACE) * (MEM_LATENCY + 2) * 3;
    localparam int SEED        = 32'h65d6;

    logic  clk;
    logic  rst_n;
    logic  if_req;
    addr_t if_addr;
    logic  if_ack;
    word_t if_data;
    logic  dbus_req;
    addr_t dbus_addr;
    word_t dbus_wdata;
    sel_t  dbus_sel;
    logic  dbus_we;
    logic  dmem_sel;
    logic  bmem_sel;
    logic  dbus_ack;
    word_t dbus_rdata;
    logic  bmem_ack;
    word_t bmem_data;
    logic  mmu_req;
    addr_t mmu_paddr;
    logic  mmu_valid;
    word_t mmu_rdata;

    word_t model [0:MEM_WORDS-1];      // Main memory as the LSU has written it
    word_t boot_img [0:BMEM_WORDS-1];

    int unsigned  cyc = 0;
    logic         fill_done = 1'b0;
    int           fetch_seed = SEED;
    int           lsu_seed = SEED ^ 32'h1;
    int           ptw_seed = SEED ^ 32'h2;
    int           err_fetch = 0;
    int           err_load = 0;
    int           err_ptw = 0;
    int           err_other = 0;
    int           exp_if_acks = 0;
    int           exp_dbus_acks = 0;
    int           exp_bmem_acks = 0;
    int           exp_mmu_acks = 0;
    int           seen_if_acks = 0;
    int           seen_dbus_acks = 0;
    int           seen_bmem_acks = 0;
    int           seen_mmu_acks = 0;
    dport_state_e dport_st;
    mem_state_e   mem_st;

    mem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_req_i     (if_req),
        .if_addr_i    (if_addr),
        .if_ack_o     (if_ack),
        .if_data_o    (if_data),
        .dbus_req_i   (dbus_req),
        .dbus_addr_i  (dbus_addr),
        .dbus_wdata_i (dbus_wdata),
        .dbus_sel_i   (dbus_sel),
        .dbus_we_i    (dbus_we),
        .dmem_sel_i   (dmem_sel),
        .bmem_sel_i   (bmem_sel),
        .dbus_ack_o   (dbus_ack),
        .dbus_rdata_o (dbus_rdata),
        .bmem_ack_o   (bmem_ack),
        .bmem_data_o  (bmem_data),
        .mmu_req_i    (mmu_req),
        .mmu_paddr_i  (mmu_paddr),
        .mmu_valid_o  (mmu_valid),
        .mmu_rdata_o  (mmu_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_fetch(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            err_fetch++;
            $display("MISMATCH %0t fetch at %h: got %h expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_load(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            err_load++;
            $display("MISMATCH %0t load at %h: got %h expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_ptw(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            err_ptw++;
            $display("MISMATCH %0t page walk read at %h: got %h expected %h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            err_other++;
            $display("MISMATCH %0t %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ack_count(input int seen, input int expected, input string port);
        if (seen != expected) begin
            err_other++;
            $display("%s pulsed %0d times for %0d requests", port, seen, expected);
        end
    endtask

    function automatic int model_index(input addr_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    task automatic idle_gap(inout int seed);
        repeat (1 + $unsigned($random(seed)) % 4) @(negedge clk);
    endtask

    // Boot region is the 0x1xxx_xxxx nibble
    task automatic fetch_word(input addr_t addr, output int unsigned ack_cyc);
        word_t       exp;
        logic        boot;
        int unsigned t0;
        boot = (addr[31:28] == 4'h1);
        exp  = boot ? boot_img[addr[5:2]] : model[model_index(addr)];
        if_req  = 1'b1;
        if_addr = addr;
        t0      = cyc;
        exp_if_acks++;
        do @(negedge clk); while (!if_ack);
        ack_cyc = cyc;
        check_fetch(if_data, exp, addr);
        if (boot) check_latency(int'(cyc - t0), 1, "boot fetch");
        if_req = 1'b0;
    endtask

    task automatic lsu_access(input logic boot, input logic we, input addr_t addr,
                              input word_t wdata, input sel_t sel, output int unsigned ack_cyc);
        word_t       exp;
        word_t       got;
        int          idx;
        int          b;
        int unsigned t0;
        idx = model_index(addr);
        exp = boot ? boot_img[addr[5:2]] : model[idx];
        if (we && !boot) begin
            for (b = 0; b < XLEN/8; b++) begin
                if (sel[b]) model[idx][8*b +: 8] = wdata[8*b +: 8];   // Selected lanes only
            end
        end
        dbus_req   = 1'b1;
        dbus_addr  = addr;
        dbus_wdata = wdata;
        dbus_sel   = sel;
        dbus_we    = we;
        dmem_sel   = !boot;
        bmem_sel   = boot;
        t0         = cyc;
        if (boot) exp_bmem_acks++;
        else exp_dbus_acks++;
        do @(negedge clk); while (!(boot ? bmem_ack : dbus_ack));
        ack_cyc = cyc;
        got     = boot ? bmem_data : dbus_rdata;
        if (!we) check_load(got, exp, addr);
        if (boot) check_latency(int'(cyc - t0), 1, "boot data access");
        dbus_req = 1'b0;
        dbus_we  = 1'b0;
        dmem_sel = 1'b0;
        bmem_sel = 1'b0;
    endtask

    task automatic ptw_read(input addr_t addr, output int unsigned ack_cyc);
        word_t exp;
        exp       = model[model_index(addr)];
        mmu_req   = 1'b1;
        mmu_paddr = addr;
        exp_mmu_acks++;
        do @(negedge clk); while (!mmu_valid);
        ack_cyc = cyc;
        check_ptw(mmu_rdata, exp, addr);
        mmu_req = 1'b0;
    endtask

    task automatic lsu_stream();
        int          n;
        int unsigned kind;
        int unsigned ack_cyc;
        word_t       r;
        word_t       wd;
        // Full-word fill of the region the MMU and fetch read later
        for (n = 0; n < FILL_WORDS; n++) begin
            lsu_access(1'b0, 1'b1, addr_t'((FILL_BASE + n) * 4), word_t'($random(lsu_seed)),
                       4'hf, ack_cyc);
            @(negedge clk);
        end
        fill_done = 1'b1;
        for (n = 0; n < N_TXN; n++) begin
            kind = $unsigned($random(lsu_seed)) % 8;
            r    = $random(lsu_seed);
            wd   = $random(lsu_seed);
            if (kind < 2) begin
                lsu_access(1'b1, kind == 1, {4'h1, 22'h0, r[3:0], 2'b00}, wd, r[7:4], ack_cyc);
            end else begin
                lsu_access(1'b0, kind < 5, {26'h0, r[3:0], 2'b00}, wd, r[7:4], ack_cyc);
            end
            idle_gap(lsu_seed);
        end
    endtask

    task automatic ptw_stream();
        int          n;
        int unsigned ack_cyc;
        word_t       r;
        wait (fill_done);
        for (n = 0; n < N_TXN; n++) begin
            r = $random(ptw_seed);
            ptw_read(addr_t'((FILL_BASE + r[4:0]) * 4), ack_cyc);
            idle_gap(ptw_seed);
        end
    endtask

    task automatic fetch_stream();
        int          n;
        int unsigned ack_cyc;
        word_t       r;
        wait (fill_done);
        for (n = 0; n < N_TXN; n++) begin
            r = $random(fetch_seed);
            if (r[31]) fetch_word({4'h1, 22'h0, r[3:0], 2'b00}, ack_cyc);
            else fetch_word(addr_t'((FILL_BASE + r[4:0]) * 4), ack_cyc);
            idle_gap(fetch_seed);
        end
    endtask

    // Requests raised on the same edge, data side must win
    task automatic same_cycle_rounds();
        int          n;
        int unsigned lsu_cyc;
        int unsigned other_cyc;
        int unsigned t0;
        word_t       r;
        for (n = 0; n < N_RACE; n++) begin
            r = $random(lsu_seed);
            fork
                lsu_access(1'b0, 1'b0, addr_t'((FILL_BASE + r[4:0]) * 4), '0, 4'hf, lsu_cyc);
                ptw_read(addr_t'((FILL_BASE + r[9:5]) * 4), other_cyc);
            join
            if (lsu_cyc > other_cyc) begin
                err_other++;
                $display("LSU ack came after the MMU valid in round %0d", n);
            end
            @(negedge clk);
            fork
                lsu_access(1'b0, 1'b0, addr_t'((FILL_BASE + r[14:10]) * 4), '0, 4'hf, lsu_cyc);
                fetch_word(addr_t'((FILL_BASE + r[19:15]) * 4), other_cyc);
            join
            if (lsu_cyc >= other_cyc) begin
                err_other++;
                $display("Fetch ack did not come after the data ack in round %0d", n);
            end
            @(negedge clk);
            t0 = cyc;   // Path is free here
            lsu_access(1'b0, 1'b0, addr_t'((FILL_BASE + r[24:20]) * 4), '0, 4'hf, lsu_cyc);
            check_latency(int'(lsu_cyc - t0), MEM_LATENCY, "free main memory read");
            @(negedge clk);
        end
    endtask

    task automatic report_errors();
        $display("Errors: fetch %0d, load %0d, ptw %0d, other %0d",
                 err_fetch, err_load, err_ptw, err_other);
    endtask

    // Ack pulses seen on each reply port
    always @(negedge clk) begin
        if (rst_n) begin
            if (if_ack) seen_if_acks++;
            if (dbus_ack) seen_dbus_acks++;
            if (bmem_ack) seen_bmem_acks++;
            if (mmu_valid) seen_mmu_acks++;
            if (dbus_ack && mmu_valid) begin
                err_other++;
                $display("dbus_ack_o and mmu_valid_o high in the same cycle at %0t", $time);
            end
        end
    end

    initial begin
        while (cyc < CYCLE_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        dport_st = dut0.dcache_port_arbiter_module.state_ff;
        mem_st   = dut0.mem_arbiter_module.state_ff;
        $display("Timeout: run did not finish within %0d cycles, arbiters in %s and %s",
                 CYCLE_LIMIT, dport_st.name(), mem_st.name());
        report_errors();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int i;
        rst_n      = 1'b0;
        if_req     = 1'b0;
        if_addr    = '0;
        dbus_req   = 1'b0;
        dbus_addr  = '0;
        dbus_wdata = '0;
        dbus_sel   = '0;
        dbus_we    = 1'b0;
        dmem_sel   = 1'b0;
        bmem_sel   = 1'b0;
        mmu_req    = 1'b0;
        mmu_paddr  = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;   // Main memory powers up zero
        end
        $readmemh(BMEM_IMAGE, boot_img);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        fork
            lsu_stream();
            ptw_stream();
            fetch_stream();
        join
        @(negedge clk);
        same_cycle_rounds();
        @(negedge clk);
        check_ack_count(seen_if_acks, exp_if_acks, "if_ack_o");
        check_ack_count(seen_dbus_acks, exp_dbus_acks, "dbus_ack_o");
        check_ack_count(seen_bmem_acks, exp_bmem_acks, "bmem_ack_o");
        check_ack_count(seen_mmu_acks, exp_mmu_acks, "mmu_valid_o");
        report_errors();
        if (err_fetch + err_load + err_ptw + err_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_mem_top

`default_nettype wire

//--- mem_top.sv
`default_nettype none

module mem_top #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic           clk,
    input  logic           rst_n,

    // Instruction fetch
    input  logic           if_req_i,
    input  soc_pkg::addr_t if_addr_i,
    output logic           if_ack_o,
    output soc_pkg::word_t if_data_o,

    // Load/store data bus
    input  logic           dbus_req_i,
    input  soc_pkg::addr_t dbus_addr_i,
    input  soc_pkg::word_t dbus_wdata_i,
    input  soc_pkg::sel_t  dbus_sel_i,
    input  logic           dbus_we_i,
    input  logic           dmem_sel_i,     // From the dbus address decoder
    input  logic           bmem_sel_i,
    output logic           dbus_ack_o,
    output soc_pkg::word_t dbus_rdata_o,
    output logic           bmem_ack_o,
    output soc_pkg::word_t bmem_data_o,

    // Page table walker
    input  logic           mmu_req_i,
    input  soc_pkg::addr_t mmu_paddr_i,
    output logic           mmu_valid_o,
    output soc_pkg::word_t mmu_rdata_o
);
    import soc_pkg::*;

    logic  bmem_iaddr_match;
    logic  bmem_i_req;
    logic  bmem_i_ack;
    word_t bmem_i_data;
    logic  bmem_d_req;
    logic  lsu_dmem_req;

    // Data path into the memory arbiter
    logic  dreq;
    addr_t daddr;
    word_t dwdata;
    sel_t  dsel;
    logic  dwe;
    logic  dack;
    word_t drdata;

    // Fetch path into the memory arbiter
    logic  freq;
    logic  fack;
    word_t frdata;

    // Main memory port
    logic  mreq;
    addr_t maddr;
    word_t mwdata;
    sel_t  msel;
    logic  mwe;
    logic  mack;
    word_t mrdata;

    assign bmem_iaddr_match = (if_addr_i[BMEM_SEL_HIGH:BMEM_SEL_LOW] == BMEM_ADDR_MATCH);

    assign bmem_i_req   = if_req_i & bmem_iaddr_match;
    assign freq         = if_req_i & ~bmem_iaddr_match;
    assign bmem_d_req   = dbus_req_i & bmem_sel_i;   // Boot writes just get an ack
    assign lsu_dmem_req = dbus_req_i & dmem_sel_i;

    boot_mem boot_mem_module (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_req_i  (bmem_i_req),
        .i_addr_i (if_addr_i),
        .i_ack_o  (bmem_i_ack),
        .i_data_o (bmem_i_data),
        .d_req_i  (bmem_d_req),
        .d_addr_i (dbus_addr_i),
        .d_ack_o  (bmem_ack_o),
        .d_data_o (bmem_data_o)
    );

    dcache_port_arbiter dcache_port_arbiter_module (
        .clk         (clk),
        .rst_n       (rst_n),
        .lsu_req_i   (lsu_dmem_req),
        .lsu_addr_i  (dbus_addr_i),
        .lsu_wdata_i (dbus_wdata_i),
        .lsu_sel_i   (dbus_sel_i),
        .lsu_we_i    (dbus_we_i),
        .mmu_req_i   (mmu_req_i),
        .mmu_paddr_i (mmu_paddr_i),
        .dreq_o      (dreq),
        .daddr_o     (daddr),
        .dwdata_o    (dwdata),
        .dsel_o      (dsel),
        .dwe_o       (dwe),
        .dack_i      (dack),
        .drdata_i    (drdata),
        .lsu_ack_o   (dbus_ack_o),
        .lsu_rdata_o (dbus_rdata_o),
        .mmu_valid_o (mmu_valid_o),
        .mmu_rdata_o (mmu_rdata_o)
    );

    mem_arbiter mem_arbiter_module (
        .clk      (clk),
        .rst_n    (rst_n),
        .dreq_i   (dreq),
        .daddr_i  (daddr),
        .dwdata_i (dwdata),
        .dsel_i   (dsel),
        .dwe_i    (dwe),
        .dack_o   (dack),
        .drdata_o (drdata),
        .freq_i   (freq),
        .faddr_i  (if_addr_i),
        .fack_o   (fack),
        .frdata_o (frdata),
        .mreq_o   (mreq),
        .maddr_o  (maddr),
        .mwdata_o (mwdata),
        .msel_o   (msel),
        .mwe_o    (mwe),
        .mack_i   (mack),
        .mrdata_i (mrdata)
    );

    main_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) main_mem_module (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (mreq),
        .addr_i  (maddr),
        .wdata_i (mwdata),
        .sel_i   (msel),
        .we_i    (mwe),
        .ack_o   (mack),
        .rdata_o (mrdata)
    );

    // Boot reply takes the fetch port when present
    assign if_ack_o  = bmem_i_ack | fack;
    assign if_data_o = bmem_i_ack ? bmem_i_data : frdata;

endmodule : mem_top

`default_nettype wire

//--- main_mem.sv
`default_nettype none

module main_mem #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req_i,
    input  soc_pkg::addr_t addr_i,
    input  soc_pkg::word_t wdata_i,
    input  soc_pkg::sel_t  sel_i,
    input  logic           we_i,
    output logic           ack_o,
    output soc_pkg::word_t rdata_o
);
    import soc_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    word_t            mem_q [0:MEM_WORDS-1] = '{default: '0};
    word_t            rdata_ff;
    logic             ack_ff;
    logic             busy_ff;
    logic [CNT_W-1:0] cnt_ff;    // Cycles left before ack
    logic [IDX_W-1:0] word_idx;
    logic             start;
    logic             fire;      // Access happens on this edge

    assign word_idx = IDX_W'((addr_i >> 2) % MEM_WORDS);

    // New access only when idle and not in the ack cycle
    assign start = req_i & ~busy_ff & ~ack_ff;
    assign fire  = (busy_ff && (cnt_ff == '0)) || (start && (MEM_LATENCY == 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_ff <= 1'b0;
            ack_ff  <= 1'b0;
            cnt_ff  <= '0;
        end else begin
            ack_ff <= fire;
            if (fire) begin
                busy_ff <= 1'b0;
            end else if (start) begin
                busy_ff <= 1'b1;
                cnt_ff  <= CNT_W'(MEM_LATENCY - 2);
            end else if (busy_ff) begin
                cnt_ff <= cnt_ff - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (we_i) begin
                for (int b = 0; b < XLEN/8; b++) begin
                    if (sel_i[b]) mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            rdata_ff <= mem_q[word_idx];   // Old word on a write
        end
    end

    assign ack_o   = ack_ff;
    assign rdata_o = rdata_ff;

endmodule : main_mem

`default_nettype wire

//--- mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic           clk,
    input  logic           rst_n,

    // Data requester
    input  logic           dreq_i,
    input  soc_pkg::addr_t daddr_i,
    input  soc_pkg::word_t dwdata_i,
    input  soc_pkg::sel_t  dsel_i,
    input  logic           dwe_i,
    output logic           dack_o,
    output soc_pkg::word_t drdata_o,

    // Fetch requester
    input  logic           freq_i,
    input  soc_pkg::addr_t faddr_i,
    output logic           fack_o,
    output soc_pkg::word_t frdata_o,

    // Main memory side
    output logic           mreq_o,
    output soc_pkg::addr_t maddr_o,
    output soc_pkg::word_t mwdata_o,
    output soc_pkg::sel_t  msel_o,
    output logic           mwe_o,
    input  logic           mack_i,
    input  soc_pkg::word_t mrdata_i
);
    import arb_pkg::*;

    mem_state_e state_ff;
    mem_state_e state_next;
    logic       fwd_data;
    logic       fwd_fetch;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= MEM_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    // Data path wins when both ask in the same cycle
    always_comb begin
        state_next = state_ff;
        fwd_data   = 1'b0;
        fwd_fetch  = 1'b0;
        dack_o     = 1'b0;
        fack_o     = 1'b0;

        case (state_ff)
            MEM_IDLE: begin
                if (dreq_i) begin
                    fwd_data   = 1'b1;
                    state_next = MEM_DATA;
                end else if (freq_i) begin
                    fwd_fetch  = 1'b1;
                    state_next = MEM_FETCH;
                end
            end

            MEM_DATA: begin
                if (mack_i) begin
                    dack_o     = 1'b1;
                    state_next = MEM_IDLE;
                end else begin
                    fwd_data = 1'b1;
                end
            end

            MEM_FETCH: begin
                if (mack_i) begin
                    fack_o     = 1'b1;
                    state_next = MEM_IDLE;
                end else begin
                    fwd_fetch = 1'b1;
                end
            end

            default: state_next = MEM_IDLE;
        endcase
    end

    assign mreq_o   = fwd_data | fwd_fetch;
    assign maddr_o  = fwd_data ? daddr_i : (fwd_fetch ? faddr_i : '0);
    assign mwdata_o = fwd_data ? dwdata_i : '0;
    assign msel_o   = fwd_data ? dsel_i : '0;
    assign mwe_o    = fwd_data & dwe_i;   // Fetch never writes

    // Read word only towards the side being acked
    assign drdata_o = dack_o ? mrdata_i : '0;
    assign frdata_o = fack_o ? mrdata_i : '0;

endmodule : mem_arbiter

`default_nettype wire

//--- dcache_port_arbiter.sv
`default_nettype none

module dcache_port_arbiter (
    input  logic           clk,
    input  logic           rst_n,

    // LSU requester
    input  logic           lsu_req_i,
    input  soc_pkg::addr_t lsu_addr_i,
    input  soc_pkg::word_t lsu_wdata_i,
    input  soc_pkg::sel_t  lsu_sel_i,
    input  logic           lsu_we_i,

    // Page table walker reads
    input  logic           mmu_req_i,
    input  soc_pkg::addr_t mmu_paddr_i,

    // Towards the memory arbiter
    output logic           dreq_o,
    output soc_pkg::addr_t daddr_o,
    output soc_pkg::word_t dwdata_o,
    output soc_pkg::sel_t  dsel_o,
    output logic           dwe_o,
    input  logic           dack_i,
    input  soc_pkg::word_t drdata_i,

    // Replies
    output logic           lsu_ack_o,
    output soc_pkg::word_t lsu_rdata_o,
    output logic           mmu_valid_o,
    output soc_pkg::word_t mmu_rdata_o
);
    import arb_pkg::*;

    dport_state_e state_ff;
    dport_state_e state_next;
    logic         fwd_lsu;   // LSU request on the data path
    logic         fwd_mmu;   // MMU request on the data path

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= DPORT_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    always_comb begin
        state_next  = state_ff;
        fwd_lsu     = 1'b0;
        fwd_mmu     = 1'b0;
        lsu_ack_o   = 1'b0;
        mmu_valid_o = 1'b0;

        case (state_ff)
            DPORT_IDLE: begin
                if (lsu_req_i) begin
                    fwd_lsu    = 1'b1;
                    state_next = DPORT_LSU;
                end else if (mmu_req_i) begin
                    fwd_mmu    = 1'b1;
                    state_next = DPORT_MMU;
                end
            end

            DPORT_LSU: begin
                if (dack_i) begin
                    lsu_ack_o  = 1'b1;
                    state_next = DPORT_IDLE;
                end else begin
                    fwd_lsu = 1'b1;   // Hold the grant
                end
            end

            DPORT_MMU: begin
                if (dack_i) begin
                    mmu_valid_o = 1'b1;
                    state_next  = DPORT_IDLE;
                end else begin
                    fwd_mmu = 1'b1;
                end
            end

            default: state_next = DPORT_IDLE;
        endcase
    end

    // MMU accesses are plain reads
    assign dreq_o   = fwd_lsu | fwd_mmu;
    assign daddr_o  = fwd_lsu ? lsu_addr_i : (fwd_mmu ? mmu_paddr_i : '0);
    assign dwdata_o = fwd_lsu ? lsu_wdata_i : '0;
    assign dsel_o   = fwd_lsu ? lsu_sel_i : '0;
    assign dwe_o    = fwd_lsu & lsu_we_i;

    assign lsu_rdata_o = lsu_ack_o ? drdata_i : '0;
    assign mmu_rdata_o = mmu_valid_o ? drdata_i : '0;

endmodule : dcache_port_arbiter

`default_nettype wire

//--- boot_mem.sv
`default_nettype none

module boot_mem (
    input  logic           clk,
    input  logic           rst_n,

    // Instruction read port
    input  logic           i_req_i,
    input  soc_pkg::addr_t i_addr_i,
    output logic           i_ack_o,
    output soc_pkg::word_t i_data_o,

    // Data read port
    input  logic           d_req_i,
    input  soc_pkg::addr_t d_addr_i,
    output logic           d_ack_o,
    output soc_pkg::word_t d_data_o
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(BMEM_WORDS);

    word_t            rom [0:BMEM_WORDS-1];
    logic [IDX_W-1:0] i_idx;
    logic [IDX_W-1:0] d_idx;
    logic             i_ack_ff;
    logic             d_ack_ff;
    word_t            i_data_ff;
    word_t            d_data_ff;

    initial begin
        $readmemh(BMEM_IMAGE, rom);
    end

    assign i_idx = i_addr_i[IDX_W+1:2];   // Word index
    assign d_idx = d_addr_i[IDX_W+1:2];

    // One ack per request, a held req does not ack twice
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i_ack_ff <= 1'b0;
            d_ack_ff <= 1'b0;
        end else begin
            i_ack_ff <= i_req_i & ~i_ack_ff;
            d_ack_ff <= d_req_i & ~d_ack_ff;
        end
    end

    always_ff @(posedge clk) begin
        i_data_ff <= rom[i_idx];
        d_data_ff <= rom[d_idx];
    end

    assign i_ack_o  = i_ack_ff;
    assign i_data_o = i_data_ff;
    assign d_ack_o  = d_ack_ff;
    assign d_data_o = d_data_ff;

endmodule : boot_mem

`default_nettype wire

//--- arb_pkg.sv
`default_nettype none

package arb_pkg;

    // Data port arbiter, LSU first
    typedef enum logic [1:0] {
        DPORT_IDLE,
        DPORT_LSU,
        DPORT_MMU
    } dport_state_e;

    // Main memory arbiter, data path before fetch
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_DATA,
        MEM_FETCH
    } mem_state_e;

endpackage : arb_pkg

`default_nettype wire

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Core word size
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   word_t;   // One data word
    typedef logic [XLEN-1:0]   addr_t;   // Byte address
    typedef logic [XLEN/8-1:0] sel_t;    // One bit per byte lane

    // Boot region decode on the upper address nibble
    localparam int BMEM_SEL_HIGH = 31;
    localparam int BMEM_SEL_LOW  = 28;

    localparam logic [BMEM_SEL_HIGH-BMEM_SEL_LOW:0] BMEM_ADDR_MATCH = 4'h1;

    // Boot ROM geometry and image
    localparam int    BMEM_WORDS = 16;
    localparam string BMEM_IMAGE = "boot.hex";

endpackage : soc_pkg

`default_nettype wire
